// File: hw/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [9:0] pc_t;
	typedef logic [11:0] dm_addr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_op_t;

	localparam int num_regs = 32;
	localparam pc_t pc_step = 10'd4;

	// instruction field positions
	localparam int opcode_hi = 30;
	localparam int opcode_lo = 25;
	localparam int rt_hi = 24;
	localparam int rt_lo = 20;
	localparam int ra_hi = 19;
	localparam int ra_lo = 15;
	localparam int rb_hi = 14;
	localparam int rb_lo = 10;
	localparam int imm5_hi = 14;
	localparam int imm5_lo = 10;
	localparam int sub_op_hi = 4;
	localparam int sub_op_lo = 0;
	// immediates all start at bit 0
	localparam int imm14_hi = 13;
	localparam int imm15_hi = 14;
	localparam int imm20_hi = 19;
	localparam int imm24_hi = 23;

	localparam opcode_t op_alu = 6'b100000;
	localparam opcode_t op_addi = 6'b101000;
	localparam opcode_t op_ori = 6'b101100;
	localparam opcode_t op_movi = 6'b100010;
	localparam opcode_t op_lwi = 6'b000010;
	localparam opcode_t op_swi = 6'b001010;
	localparam opcode_t op_beq = 6'b100110;
	localparam opcode_t op_j = 6'b100100;

	localparam sub_op_t sub_add = 5'b00000;
	localparam sub_op_t sub_sub = 5'b00001;
	localparam sub_op_t sub_and = 5'b00010;
	localparam sub_op_t sub_xor = 5'b00011;
	localparam sub_op_t sub_or = 5'b00100;
	localparam sub_op_t sub_slli = 5'b01000;
	localparam sub_op_t sub_srli = 5'b01001;
	// movi only and never decoded from the sub-op field
	localparam sub_op_t alu_pass = 5'b11111;

	// alu second operand
	localparam logic [2:0] src2_reg = 3'd0;
	localparam logic [2:0] src2_imm5 = 3'd1;
	localparam logic [2:0] src2_imm15s = 3'd2;
	localparam logic [2:0] src2_imm15z = 3'd3;
	localparam logic [2:0] src2_imm15w = 3'd4;
	localparam logic [2:0] src2_imm20s = 3'd5;

	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mem = 2'd1;

	localparam logic [1:0] pc_seq = 2'd0;
	localparam logic [1:0] pc_branch = 2'd1;
	localparam logic [1:0] pc_jump = 2'd2;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memaccess,
		st_writeback
	} core_state_t;

endpackage

// File: hw/core_controller.sv
`timescale 1ns/1ps

module core_controller (
	input  logic                DM_enable,
	input  logic                reset,
	input  core_pkg::word_t     instruction,
	input  logic                alu_zero,
	output logic                im_read,
	output logic                dm_access,
	output logic                dm_read,
	output logic                dm_write,
	output logic                en_decode,
	output logic                en_execute,
	output logic                reg_write,
	output core_pkg::reg_addr_t ra_addr,
	output core_pkg::reg_addr_t rb_addr,
	output core_pkg::reg_addr_t rt_addr,
	output core_pkg::sub_op_t   alu_op,
	output logic [2:0]          src2_sel,
	output logic [1:0]          wb_sel,
	output logic [1:0]          pc_sel,
	output logic [19:0]         imm_field,
	output core_pkg::pc_t       branch_off
);

	core_pkg::core_state_t state;
	core_pkg::core_state_t state_next;
	core_pkg::word_t instr_q;
	core_pkg::opcode_t opcode;
	core_pkg::sub_op_t sub_op;
	logic writes_rt;
	logic is_load;
	logic is_store;

	always_comb begin
		case (state)
			core_pkg::st_fetch: state_next = core_pkg::st_decode;
			core_pkg::st_decode: state_next = core_pkg::st_execute;
			core_pkg::st_execute: state_next = core_pkg::st_memaccess;
			core_pkg::st_memaccess: state_next = core_pkg::st_writeback;
			default: state_next = core_pkg::st_fetch;
		endcase
	end

	always_ff @(posedge DM_enable) begin
		if (reset) begin
			state <= core_pkg::st_fetch;
			instr_q <= '0;
		end else begin
			state <= state_next;
			// imem is combinational so the word is valid by end of fetch
			if (state == core_pkg::st_fetch) begin
				instr_q <= instruction;
			end
		end
	end

	assign opcode = instr_q[core_pkg::opcode_hi:core_pkg::opcode_lo];
	assign sub_op = instr_q[core_pkg::sub_op_hi:core_pkg::sub_op_lo];
	assign ra_addr = instr_q[core_pkg::ra_hi:core_pkg::ra_lo];
	assign rt_addr = instr_q[core_pkg::rt_hi:core_pkg::rt_lo];
	// beq compares rt against ra, so rt goes out on the rb port
	assign rb_addr = (opcode == core_pkg::op_beq) ? instr_q[core_pkg::rt_hi:core_pkg::rt_lo]
		: instr_q[core_pkg::rb_hi:core_pkg::rb_lo];
	assign imm_field = instr_q[core_pkg::imm20_hi:0];

	assign im_read = (state == core_pkg::st_fetch);
	assign en_decode = (state == core_pkg::st_decode);
	assign en_execute = (state == core_pkg::st_execute);
	assign dm_access = (state == core_pkg::st_memaccess);
	assign dm_read = dm_access && is_load;
	assign dm_write = dm_access && is_store;
	assign reg_write = (state == core_pkg::st_writeback) && writes_rt;

	always_comb begin
		alu_op = core_pkg::sub_add;
		src2_sel = core_pkg::src2_reg;
		wb_sel = core_pkg::wb_alu;
		pc_sel = core_pkg::pc_seq;
		branch_off = '0;
		writes_rt = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		case (opcode)
			core_pkg::op_alu: begin
				alu_op = sub_op;
				writes_rt = 1'b1;
				if (sub_op == core_pkg::sub_slli || sub_op == core_pkg::sub_srli) begin
					src2_sel = core_pkg::src2_imm5;
				end
			end
			core_pkg::op_addi: begin
				src2_sel = core_pkg::src2_imm15s;
				writes_rt = 1'b1;
			end
			core_pkg::op_ori: begin
				alu_op = core_pkg::sub_or;
				src2_sel = core_pkg::src2_imm15z;
				writes_rt = 1'b1;
			end
			core_pkg::op_movi: begin
				alu_op = core_pkg::alu_pass;
				src2_sel = core_pkg::src2_imm20s;
				writes_rt = 1'b1;
			end
			core_pkg::op_lwi: begin
				src2_sel = core_pkg::src2_imm15w;
				wb_sel = core_pkg::wb_mem;
				writes_rt = 1'b1;
				is_load = 1'b1;
			end
			core_pkg::op_swi: begin
				src2_sel = core_pkg::src2_imm15w;
				is_store = 1'b1;
			end
			core_pkg::op_beq: begin
				alu_op = core_pkg::sub_sub;
				// scaled offset keeps only the low pc bits
				branch_off = core_pkg::pc_t'({instr_q[core_pkg::imm14_hi:0], 2'b00});
				if (alu_zero) begin
					pc_sel = core_pkg::pc_branch;
				end
			end
			core_pkg::op_j: begin
				branch_off = core_pkg::pc_t'({instr_q[core_pkg::imm24_hi:0], 2'b00});
				pc_sel = core_pkg::pc_jump;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hw/core_alu.sv
`timescale 1ns/1ps

module core_alu (
	input  logic              DM_enable,
	input  logic              reset,
	input  logic              en_execute,
	input  core_pkg::word_t   src1,
	input  core_pkg::word_t   src2,
	input  core_pkg::sub_op_t alu_op,
	output core_pkg::word_t   alu_result,
	output logic              alu_overflow,
	output logic              alu_zero
);

	core_pkg::word_t sum;
	core_pkg::word_t diff;
	core_pkg::word_t result_d;
	logic overflow_d;

	assign sum = src1 + src2;
	assign diff = src1 - src2;

	always_comb begin
		overflow_d = 1'b0;
		case (alu_op)
			core_pkg::sub_add: begin
				result_d = sum;
				overflow_d = (src1[31] == src2[31]) && (sum[31] != src1[31]);
			end
			core_pkg::sub_sub: begin
				result_d = diff;
				overflow_d = (src1[31] != src2[31]) && (diff[31] != src1[31]);
			end
			core_pkg::sub_and: result_d = src1 & src2;
			core_pkg::sub_or: result_d = src1 | src2;
			core_pkg::sub_xor: result_d = src1 ^ src2;
			// shift amount is the low five bits
			core_pkg::sub_slli: result_d = src1 << src2[4:0];
			core_pkg::sub_srli: result_d = src1 >> src2[4:0];
			core_pkg::alu_pass: result_d = src2;
			default: result_d = '0;
		endcase
	end

	always_ff @(posedge DM_enable) begin
		if (reset) begin
			alu_overflow <= 1'b0;
		end else if (en_execute) begin
			alu_overflow <= overflow_d;
		end
	end

	always_ff @(posedge DM_enable) begin
		if (en_execute) begin
			alu_result <= result_d;
		end
	end

	// operands are held from decode to the next decode,
	// so beq sees the compare inside its own execute
	assign alu_zero = (src1 == src2);

endmodule

// File: hw/core_regfile.sv
`timescale 1ns/1ps

module core_regfile (
	input  logic                DM_enable,
	input  logic                reset,
	input  logic                en_decode,
	input  logic                reg_write,
	input  core_pkg::reg_addr_t ra_addr,
	input  core_pkg::reg_addr_t rb_addr,
	input  core_pkg::reg_addr_t rt_addr,
	input  core_pkg::word_t     wb_data,
	output core_pkg::word_t     ra_data,
	output core_pkg::word_t     rb_data,
	output core_pkg::word_t     rt_data
);

	core_pkg::word_t regs [core_pkg::num_regs];

	always_ff @(posedge DM_enable) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[rt_addr] <= wb_data;
		end
	end

	// read ports hold until the next decode
	always_ff @(posedge DM_enable) begin
		if (en_decode) begin
			ra_data <= regs[ra_addr];
			rb_data <= regs[rb_addr];
			rt_data <= regs[rt_addr];
		end
	end

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  logic [2:0]      src2_sel,
	input  logic [1:0]      wb_sel,
	input  logic [19:0]     imm_field,
	input  core_pkg::word_t rb_data,
	input  core_pkg::word_t alu_result,
	input  core_pkg::word_t mem_data,
	output core_pkg::word_t src2,
	output core_pkg::word_t wb_data
);

	logic imm15_sign;
	logic imm20_sign;
	core_pkg::word_t imm5_z;
	core_pkg::word_t imm15_s;
	core_pkg::word_t imm15_z;
	core_pkg::word_t imm15_w;
	core_pkg::word_t imm20_s;

	assign imm15_sign = imm_field[core_pkg::imm15_hi];
	assign imm20_sign = imm_field[core_pkg::imm20_hi];

	assign imm5_z = {27'b0, imm_field[core_pkg::imm5_hi:core_pkg::imm5_lo]};
	assign imm15_s = {{17{imm15_sign}}, imm_field[core_pkg::imm15_hi:0]};
	assign imm15_z = {17'b0, imm_field[core_pkg::imm15_hi:0]};
	// word offset for lwi and swi
	assign imm15_w = {{15{imm15_sign}}, imm_field[core_pkg::imm15_hi:0], 2'b00};
	assign imm20_s = {{12{imm20_sign}}, imm_field[core_pkg::imm20_hi:0]};

	always_comb begin
		case (src2_sel)
			core_pkg::src2_imm5: src2 = imm5_z;
			core_pkg::src2_imm15s: src2 = imm15_s;
			core_pkg::src2_imm15z: src2 = imm15_z;
			core_pkg::src2_imm15w: src2 = imm15_w;
			core_pkg::src2_imm20s: src2 = imm20_s;
			default: src2 = rb_data;
		endcase
	end

	assign wb_data = (wb_sel == core_pkg::wb_mem) ? mem_data : alu_result;

endmodule

// File: hw/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input  logic          DM_enable,
	input  logic          reset,
	input  logic          en_execute,
	input  logic [1:0]    pc_sel,
	input  core_pkg::pc_t branch_off,
	output core_pkg::pc_t pc
);

	core_pkg::pc_t pc_next;

	// targets are relative to the pc of the executing instruction
	always_comb begin
		case (pc_sel)
			core_pkg::pc_branch, core_pkg::pc_jump: pc_next = pc + branch_off;
			default: pc_next = pc + core_pkg::pc_step;
		endcase
	end

	always_ff @(posedge DM_enable) begin
		if (reset) begin
			pc <= '0;
		end else if (en_execute) begin
			pc <= pc_next;
		end
	end

endmodule

// File: hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic               DM_enable,
	input  logic               reset,
	input  core_pkg::word_t    instruction,
	input  core_pkg::word_t    dm_out,
	output logic               im_read,
	output core_pkg::pc_t      im_address,
	output logic               dm_access,
	output logic               dm_read,
	output logic               dm_write,
	output core_pkg::dm_addr_t dm_address,
	output core_pkg::word_t    dm_in,
	output logic               alu_overflow
);

	// controller to datapath
	logic en_decode;
	logic en_execute;
	logic reg_write;
	core_pkg::reg_addr_t ra_addr;
	core_pkg::reg_addr_t rb_addr;
	core_pkg::reg_addr_t rt_addr;
	core_pkg::sub_op_t alu_op;
	logic [2:0] src2_sel;
	logic [1:0] wb_sel;
	logic [1:0] pc_sel;
	logic [19:0] imm_field;
	core_pkg::pc_t branch_off;

	// datapath
	core_pkg::word_t ra_data;
	core_pkg::word_t rb_data;
	core_pkg::word_t rt_data;
	core_pkg::word_t src2;
	core_pkg::word_t wb_data;
	core_pkg::word_t alu_result;
	core_pkg::word_t mem_data;
	core_pkg::pc_t pc;
	logic alu_zero;

	// load data captured at the end of memaccess
	always_ff @(posedge DM_enable) begin
		if (dm_read) begin
			mem_data <= dm_out;
		end
	end

	assign im_address = pc;
	assign dm_address = core_pkg::dm_addr_t'(alu_result);
	assign dm_in = rt_data;

	core_controller controller_inst (
		.DM_enable  (DM_enable),
		.reset      (reset),
		.instruction(instruction),
		.alu_zero   (alu_zero),
		.im_read    (im_read),
		.dm_access  (dm_access),
		.dm_read    (dm_read),
		.dm_write   (dm_write),
		.en_decode  (en_decode),
		.en_execute (en_execute),
		.reg_write  (reg_write),
		.ra_addr    (ra_addr),
		.rb_addr    (rb_addr),
		.rt_addr    (rt_addr),
		.alu_op     (alu_op),
		.src2_sel   (src2_sel),
		.wb_sel     (wb_sel),
		.pc_sel     (pc_sel),
		.imm_field  (imm_field),
		.branch_off (branch_off)
	);

	core_regfile regfile_inst (
		.DM_enable(DM_enable),
		.reset    (reset),
		.en_decode(en_decode),
		.reg_write(reg_write),
		.ra_addr  (ra_addr),
		.rb_addr  (rb_addr),
		.rt_addr  (rt_addr),
		.wb_data  (wb_data),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.rt_data  (rt_data)
	);

	operand_select operand_select_inst (
		.src2_sel  (src2_sel),
		.wb_sel    (wb_sel),
		.imm_field (imm_field),
		.rb_data   (rb_data),
		.alu_result(alu_result),
		.mem_data  (mem_data),
		.src2      (src2),
		.wb_data   (wb_data)
	);

	core_alu alu_inst (
		.DM_enable   (DM_enable),
		.reset       (reset),
		.en_execute  (en_execute),
		.src1        (ra_data),
		.src2        (src2),
		.alu_op      (alu_op),
		.alu_result  (alu_result),
		.alu_overflow(alu_overflow),
		.alu_zero    (alu_zero)
	);

	pc_unit pc_unit_inst (
		.DM_enable (DM_enable),
		.reset     (reset),
		.en_execute(en_execute),
		.pc_sel    (pc_sel),
		.branch_off(branch_off),
		.pc        (pc)
	);

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic DM_enable,
	output logic reset
);

	initial begin
		DM_enable = 1'b0;
		forever #2 DM_enable = ~DM_enable;
	end

	// held over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge DM_enable);
		@(negedge DM_enable);
		reset = 1'b0;
	end

endmodule

// File: testbench/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
	input logic DM_enable,
	input logic reset,
	input logic im_read,
	input logic dm_access,
	input logic dm_read,
	input logic dm_write
);

	read_write_exclusive: assert property (@(posedge DM_enable) disable iff (reset)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high in the same cycle");

	// data strobes only inside the memory access state
	strobe_needs_access: assert property (@(posedge DM_enable) disable iff (reset)
		(dm_read || dm_write) |-> dm_access)
		else $error("data strobe without dm_access");

	fetch_access_exclusive: assert property (@(posedge DM_enable) disable iff (reset)
		!(im_read && dm_access))
		else $error("im_read and dm_access high in the same cycle");

endmodule

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	// executed instructions per test
	localparam int total_instrs = 4 + 18 + 4 + 16 + 9 + 5;
	localparam int timeout_cycles = total_instrs * 5 + 50;

	logic DM_enable;
	logic por_reset;
	logic test_reset;
	logic reset;
	core_pkg::word_t instruction;
	core_pkg::word_t dm_out;
	logic im_read;
	core_pkg::pc_t im_address;
	logic dm_access;
	logic dm_read;
	logic dm_write;
	core_pkg::dm_addr_t dm_address;
	core_pkg::word_t dm_in;
	logic alu_overflow;

	core_pkg::word_t imem [256];
	core_pkg::word_t dmem [1024];
	int prog_len;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	// observed activity of the current test
	core_pkg::pc_t fetch_addr_q[$];
	int fetch_cycle_q[$];
	logic ovf_q[$];
	core_pkg::dm_addr_t store_addr_q[$];
	core_pkg::word_t store_data_q[$];
	core_pkg::dm_addr_t load_addr_q[$];
	core_pkg::dm_addr_t exp_addr_q[$];
	core_pkg::word_t exp_data_q[$];

	assign reset = por_reset | test_reset;

	tb_clock clock_inst (
		.DM_enable(DM_enable),
		.reset    (por_reset)
	);

	cpu_top cpu_top_inst (
		.DM_enable   (DM_enable),
		.reset       (reset),
		.instruction (instruction),
		.dm_out      (dm_out),
		.im_read     (im_read),
		.im_address  (im_address),
		.dm_access   (dm_access),
		.dm_read     (dm_read),
		.dm_write    (dm_write),
		.dm_address  (dm_address),
		.dm_in       (dm_in),
		.alu_overflow(alu_overflow)
	);

	bind cpu_top cpu_chk chk_inst (
		.DM_enable(DM_enable),
		.reset    (reset),
		.im_read  (im_read),
		.dm_access(dm_access),
		.dm_read  (dm_read),
		.dm_write (dm_write)
	);

	always @(posedge DM_enable) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: run did not complete within %0d cycles", timeout_cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic core_pkg::word_t encode_reg(input core_pkg::sub_op_t sub,
		input core_pkg::reg_addr_t rt, input core_pkg::reg_addr_t ra,
		input core_pkg::reg_addr_t rb);
		return {1'b0, core_pkg::op_alu, rt, ra, rb, 5'b00000, sub};
	endfunction

	function automatic core_pkg::word_t encode_imm15(input core_pkg::opcode_t op,
		input core_pkg::reg_addr_t rt, input core_pkg::reg_addr_t ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic core_pkg::word_t encode_movi(input core_pkg::reg_addr_t rt,
		input logic [19:0] imm);
		return {1'b0, core_pkg::op_movi, rt, imm};
	endfunction

	function automatic core_pkg::word_t encode_beq(input core_pkg::reg_addr_t rt,
		input core_pkg::reg_addr_t ra, input logic [13:0] imm);
		return {1'b0, core_pkg::op_beq, rt, ra, 1'b0, imm};
	endfunction

	function automatic core_pkg::word_t encode_j(input logic [23:0] imm);
		return {1'b0, core_pkg::op_j, 1'b0, imm};
	endfunction

	task automatic emit(input core_pkg::word_t word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// unknown opcode 6'b111111 plus the word index runs as a nop
	task automatic load_blank_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h7e00_0000 | core_pkg::word_t'(i);
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = {20'hd0000, 12'(i * 4)};
		end
		prog_len = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic load_word(input core_pkg::reg_addr_t rt, output core_pkg::word_t value);
		logic [19:0] hi;
		logic [14:0] lo;
		hi = 20'($urandom());
		lo = 15'($urandom());
		emit(encode_movi(rt, hi));
		emit(encode_imm15(core_pkg::op_ori, rt, rt, lo));
		// movi sign-extends and ori zero-extends
		value = {{12{hi[19]}}, hi} | {17'b0, lo};
	endtask

	task automatic service_memories();
		instruction = imem[im_address[9:2]];
		dm_out = dmem[dm_address[11:2]];
		if (dm_write) begin
			dmem[dm_address[11:2]] = dm_in;
			store_addr_q.push_back(dm_address);
			store_data_q.push_back(dm_in);
		end
		if (dm_read) begin
			load_addr_q.push_back(dm_address);
		end
	endtask

	task automatic apply_reset();
		fetch_addr_q.delete();
		fetch_cycle_q.delete();
		ovf_q.delete();
		store_addr_q.delete();
		store_data_q.delete();
		load_addr_q.delete();
		@(negedge DM_enable);
		test_reset = 1'b1;
		repeat (2) begin
			@(negedge DM_enable);
			service_memories();
		end
		test_reset = 1'b0;
	endtask

	// runs until the fetch after the last instruction has started
	task automatic run_instrs(input int n_instr);
		int fetches;
		int cycle;
		fetches = 0;
		cycle = 0;
		while (fetches <= n_instr) begin
			if (cycle > 0) begin
				@(negedge DM_enable);
				service_memories();
			end
			if (im_read) begin
				fetch_addr_q.push_back(im_address);
				fetch_cycle_q.push_back(cycle);
				ovf_q.push_back(alu_overflow);
				fetches++;
			end
			cycle++;
		end
	endtask

	task automatic expect_word(input string test_name, input core_pkg::word_t expected,
		input core_pkg::word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic expect_count(input string test_name, input string what,
		input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
		end
	endtask

	task automatic compare_stores(input string test_name);
		expect_count(test_name, "stores", exp_data_q.size(), store_data_q.size());
		for (int i = 0; i < exp_data_q.size() && i < store_data_q.size(); i++) begin
			expect_word({test_name, " address"}, 32'(exp_addr_q[i]), 32'(store_addr_q[i]));
			expect_word({test_name, " data"}, exp_data_q[i], store_data_q[i]);
		end
	endtask

	task automatic test_reset_state();
		load_blank_program();
		apply_reset();
		expect_word("reset im_read", 32'd1, 32'(im_read));
		expect_word("reset im_address", 32'd0, 32'(im_address));
		expect_word("reset dm_access", 32'd0, 32'(dm_access));
		expect_word("reset dm_read", 32'd0, 32'(dm_read));
		expect_word("reset dm_write", 32'd0, 32'(dm_write));
		run_instrs(4);
		expect_count("reset", "fetches", 5, fetch_addr_q.size());
		for (int i = 1; i < fetch_addr_q.size(); i++) begin
			expect_word("reset fetch spacing", 32'd5,
				32'(fetch_cycle_q[i] - fetch_cycle_q[i - 1]));
			expect_word("reset fetch address", 32'(i * 4), 32'(fetch_addr_q[i]));
		end
		expect_count("reset", "stores", 0, store_data_q.size());
	endtask

	task automatic store_result(input core_pkg::sub_op_t sub, input core_pkg::reg_addr_t rb,
		input int slot);
		emit(encode_reg(sub, 5'd3, 5'd1, rb));
		emit(encode_imm15(core_pkg::op_swi, 5'd3, 5'd0, 15'(slot)));
		exp_addr_q.push_back(12'(slot * 4));
	endtask

	task automatic test_alu_ops();
		core_pkg::word_t a;
		core_pkg::word_t b;
		logic [4:0] sh;
		load_blank_program();
		load_word(5'd1, a);
		load_word(5'd2, b);
		sh = 5'($urandom_range(1, 31));
		store_result(core_pkg::sub_add, 5'd2, 0);
		store_result(core_pkg::sub_sub, 5'd2, 1);
		store_result(core_pkg::sub_and, 5'd2, 2);
		store_result(core_pkg::sub_or, 5'd2, 3);
		store_result(core_pkg::sub_xor, 5'd2, 4);
		store_result(core_pkg::sub_slli, sh, 5);
		store_result(core_pkg::sub_srli, sh, 6);
		exp_data_q.push_back(a + b);
		exp_data_q.push_back(a - b);
		exp_data_q.push_back(a & b);
		exp_data_q.push_back(a | b);
		exp_data_q.push_back(a ^ b);
		exp_data_q.push_back(a << sh);
		exp_data_q.push_back(a >> sh);
		apply_reset();
		run_instrs(18);
		compare_stores("alu_ops");
	endtask

	task automatic test_extension();
		logic [14:0] imm_neg;
		logic [14:0] imm_high;
		load_blank_program();
		imm_neg = {1'b1, 14'($urandom())};
		imm_high = {1'b1, 14'($urandom())};
		emit(encode_imm15(core_pkg::op_addi, 5'd4, 5'd0, imm_neg));
		emit(encode_imm15(core_pkg::op_ori, 5'd5, 5'd0, imm_high));
		emit(encode_imm15(core_pkg::op_swi, 5'd4, 5'd0, 15'd0));
		emit(encode_imm15(core_pkg::op_swi, 5'd5, 5'd0, 15'd1));
		exp_addr_q.push_back(12'd0);
		exp_addr_q.push_back(12'd4);
		exp_data_q.push_back({{17{1'b1}}, imm_neg});
		exp_data_q.push_back({17'b0, imm_high});
		apply_reset();
		run_instrs(4);
		compare_stores("extension");
	endtask

	task automatic test_load_store();
		core_pkg::word_t words [3];
		int base;
		load_blank_program();
		base = int'($urandom_range(64, 900)) * 4;
		emit(encode_movi(5'd6, 20'(base)));
		for (int i = 0; i < 3; i++) begin
			load_word(5'(1 + i), words[i]);
		end
		for (int i = 0; i < 3; i++) begin
			emit(encode_imm15(core_pkg::op_swi, 5'(1 + i), 5'd6, 15'(i)));
		end
		for (int i = 0; i < 3; i++) begin
			emit(encode_imm15(core_pkg::op_lwi, 5'(7 + i), 5'd6, 15'(i)));
		end
		// copies land eight words above the originals
		for (int i = 0; i < 3; i++) begin
			emit(encode_imm15(core_pkg::op_swi, 5'(7 + i), 5'd6, 15'(8 + i)));
		end
		for (int i = 0; i < 6; i++) begin
			exp_addr_q.push_back(12'(base + (i % 3) * 4 + (i / 3) * 32));
			exp_data_q.push_back(words[i % 3]);
		end
		apply_reset();
		run_instrs(16);
		compare_stores("load_store");
		expect_count("load_store", "loads", 3, load_addr_q.size());
		for (int i = 0; i < load_addr_q.size() && i < 3; i++) begin
			expect_word("load_store load address", 32'(base + i * 4), 32'(load_addr_q[i]));
		end
	endtask

	task automatic test_branches();
		logic [19:0] val;
		int exp_pc [10];
		load_blank_program();
		val = 20'($urandom());
		emit(encode_movi(5'd1, val));
		emit(encode_movi(5'd2, val));
		emit(encode_movi(5'd3, val ^ 20'd1));
		emit(encode_beq(5'd1, 5'd2, 14'd3));
		prog_len = 6;
		emit(encode_beq(5'd1, 5'd3, 14'd5));
		emit(encode_j(24'd4));
		emit(encode_j(24'd5));
		prog_len = 11;
		emit(encode_j(-24'sd3));
		// taken beq, untaken beq, forward j, backward j, forward j
		exp_pc = '{0, 4, 8, 12, 12 + 3 * 4, 24 + 4, 28 + 4 * 4, 44 - 3 * 4, 32 + 5 * 4, 52 + 4};
		apply_reset();
		run_instrs(9);
		expect_count("branches", "fetches", 10, fetch_addr_q.size());
		for (int i = 0; i < fetch_addr_q.size() && i < 10; i++) begin
			expect_word("branches im_address", 32'(exp_pc[i]), 32'(fetch_addr_q[i]));
		end
	endtask

	task automatic test_overflow();
		core_pkg::word_t a;
		core_pkg::word_t sum;
		load_blank_program();
		emit(encode_movi(5'd1, 20'hfffff));
		emit(encode_reg(core_pkg::sub_srli, 5'd1, 5'd1, 5'd1));
		emit(encode_imm15(core_pkg::op_addi, 5'd2, 5'd1, 15'd1));
		emit(encode_reg(core_pkg::sub_add, 5'd3, 5'd0, 5'd0));
		emit(encode_imm15(core_pkg::op_swi, 5'd2, 5'd0, 15'd0));
		a = 32'hffff_ffff >> 1;
		sum = a + 32'd1;
		exp_addr_q.push_back(12'd0);
		exp_data_q.push_back(sum);
		apply_reset();
		run_instrs(5);
		compare_stores("overflow");
		expect_count("overflow", "fetches", 6, ovf_q.size());
		if (ovf_q.size() == 6) begin
			expect_word("overflow before addi", 32'd0, 32'(ovf_q[2]));
			expect_word("overflow after addi", 32'd1, 32'(ovf_q[3]));
			expect_word("overflow after add", 32'd0, 32'(ovf_q[4]));
		end
	endtask

	initial begin
		void'($urandom(90353));
		test_reset = 1'b0;
		instruction = '0;
		dm_out = '0;
		wait (por_reset == 1'b0);
		test_reset_state();
		test_alu_ops();
		test_extension();
		test_load_store();
		test_branches();
		test_overflow();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
hw/core_pkg.sv
hw/core_controller.sv
hw/core_alu.sv
hw/core_regfile.sv
hw/operand_select.sv
hw/pc_unit.sv
hw/cpu_top.sv
testbench/tb_clock.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = cpu_tb
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_TEXT = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
